// File: src.f
+incdir+logic
logic/exec_pkg.sv
logic/operand_select.sv
logic/alu.sv
logic/alu_unit.sv
logic/address_unit.sv
logic/mult_stage.sv
logic/mult_pipe.sv
logic/issue_ctrl.sv
logic/exec_stage.sv
sim/exec_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/exec_stage_tb.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_stage_tb;
    import exec_pkg::*;

    localparam int kind_cdb = 0;
    localparam int kind_lb  = 1;
    localparam int kind_br  = 2;
    localparam int num_tags = 1 << `ROB_TAG_BITS;
    localparam int num_entries = 20 + 8 + 6 + 4 + 8;
    localparam int drain_cycles = `MULT_STAGES + 8;
    localparam int timeout_cycles = num_entries * (`MULT_STAGES + 8) + 200;

    logic           clock;
    logic           reset;
    logic           issue_req;
    ready_entry_t   issue_entry;
    logic           issue_ack;
    cdb_t           cdb;
    lb_packet_t     lb_out;
    branch_result_t branch_out;

    // Scoreboard indexed by ROB tag
    logic       pending   [num_tags];
    int         exp_kind  [num_tags];
    word_t      exp_value [num_tags];
    logic       exp_taken [num_tags];
    logic [2:0] exp_size  [num_tags];
    string      exp_name  [num_tags];

    rob_tag_t next_tag;
    int       pending_count;
    int       error_count;
    int       check_count;
    int       test_errors;
    int       test_checks;
    string    test_name;

    exec_stage dut (
        .clock      (clock),
        .reset      (reset),
        .issue_req  (issue_req),
        .issue_entry(issue_entry),
        .issue_ack  (issue_ack),
        .cdb        (cdb),
        .lb_out     (lb_out),
        .branch_out (branch_out)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clock);
        $display("Timeout after %0d cycles, the DUT stopped answering", timeout_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic word_t ref_imm(logic [31:0] i, opb_sel_t sel);
        case (sel)
            opb_i_imm: return {{20{i[31]}}, i[31:20]};
            opb_s_imm: return {{20{i[31]}}, i[31:25], i[11:7]};
            opb_b_imm: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            opb_u_imm: return {i[31:12], 12'h000};
            opb_j_imm: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default:   return '0;
        endcase
    endfunction

    // RV32I rules for the value each entry should produce
    function automatic word_t exp_result(ready_entry_t e);
        word_t       a;
        word_t       b;
        logic [63:0] full;
        if (e.instr.fu_kind == fu_mult) begin
            full = {32'b0, e.rs1_value} * {32'b0, e.rs2_value};
            return full[31:0];  // MUL keeps the low half
        end
        case (e.instr.opa_select)
            opa_rs1: a = e.rs1_value;
            opa_npc: a = e.instr.npc;
            opa_pc:  a = e.instr.pc;
            default: a = '0;
        endcase
        b = (e.instr.opb_select == opb_rs2) ? e.rs2_value
                                            : ref_imm(e.instr.inst, e.instr.opb_select);
        case (e.instr.alu_func)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_slt:  return {31'b0, $signed(a) < $signed(b)};
            alu_sltu: return {31'b0, a < b};
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return word_t'($signed(a) >>> b[4:0]);
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_taken(ready_entry_t e);
        if (e.instr.uncond_branch) return 1'b1;  // Jumps always go
        case (e.instr.inst[14:12])
            3'd0:    return e.rs1_value == e.rs2_value;
            3'd1:    return e.rs1_value != e.rs2_value;
            3'd4:    return $signed(e.rs1_value) < $signed(e.rs2_value);
            3'd5:    return $signed(e.rs1_value) >= $signed(e.rs2_value);
            3'd6:    return e.rs1_value < e.rs2_value;
            3'd7:    return e.rs1_value >= e.rs2_value;
            default: return 1'b0;
        endcase
    endfunction

    function automatic ready_entry_t make_entry(fu_kind_t fu, alu_func_t func, opa_sel_t sa,
                                                opb_sel_t sb, logic [2:0] funct3);
        ready_entry_t e;
        e = '0;
        e.instr.inst = $urandom;
        e.instr.inst[14:12] = funct3;
        e.instr.pc = $urandom & 32'hffff_fffc;
        e.instr.npc = e.instr.pc + 32'd4;
        e.instr.opa_select = sa;
        e.instr.opb_select = sb;
        e.instr.alu_func = func;
        e.instr.fu_kind = fu;
        e.rs1_value = $urandom;
        e.rs2_value = $urandom;
        return e;
    endfunction

    task automatic note_failure(input string msg);
        $display("%s", msg);
        error_count++;
        test_errors++;
    endtask

    task automatic report_value(input rob_tag_t tag, input string field, input word_t exp,
                                input word_t act);
        note_failure($sformatf("ERROR %s: tag %0d %s expected %h actual %h",
                               exp_name[tag], tag, field, exp, act));
    endtask

    // Four-phase req/ack with the expected result registered first
    task automatic issue(input ready_entry_t e, input int kind);
        rob_tag_t tag;
        tag = next_tag;
        next_tag = next_tag + 1'b1;
        e.rd_tag = tag;
        assert (!pending[tag]) else
            note_failure($sformatf("Tag %0d reused while its result is outstanding", tag));
        pending[tag] = 1'b1;
        exp_kind[tag] = kind;
        exp_value[tag] = exp_result(e);
        exp_taken[tag] = branch_taken(e);
        exp_size[tag] = e.instr.inst[14:12];
        exp_name[tag] = test_name;
        pending_count++;
        @(posedge clock);
        issue_entry <= e;
        issue_req <= 1'b1;
        do @(negedge clock); while (!issue_ack);
        @(posedge clock);
        issue_req <= 1'b0;
        do @(negedge clock); while (issue_ack);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        while (pending_count != 0 && waited < drain_cycles) begin
            @(negedge clock);
            waited++;
        end
        for (int t = 0; t < num_tags; t++) begin
            assert (!pending[t]) else begin
                note_failure($sformatf("Test %s never got a result for tag %0d", exp_name[t], t));
                pending[t] = 1'b0;
                pending_count--;
            end
        end
        $display("test %-10s %0d results checked, %0d errors", test_name, test_checks, test_errors);
    endtask

    // Claims a scoreboard slot, returns 1 when the bus is the right one for the tag
    task automatic take_result(input rob_tag_t tag, input int kind, input string bus,
                               output logic ok);
        ok = pending[tag] && exp_kind[tag] == kind;
        assert (pending[tag]) else
            note_failure($sformatf("Result on %s for tag %0d was not expected or came twice",
                                   bus, tag));
        assert (!pending[tag] || exp_kind[tag] == kind) else
            note_failure($sformatf("Test %s put tag %0d on %s, which it must not use",
                                   exp_name[tag], tag, bus));
        if (ok) begin
            pending[tag] = 1'b0;
            pending_count--;
            check_count++;
            test_checks++;
        end
    endtask

    always @(negedge clock) begin : compare
        logic ok;
        if (!reset && cdb.valid) begin
            take_result(cdb.rob_tag, kind_cdb, "cdb", ok);
            if (ok) begin
                assert (cdb.value == exp_value[cdb.rob_tag]) else
                    report_value(cdb.rob_tag, "value", exp_value[cdb.rob_tag], cdb.value);
            end
        end
        if (!reset && lb_out.valid) begin
            take_result(lb_out.rd_tag, kind_lb, "lb_out", ok);
            if (ok) begin
                assert (lb_out.address == exp_value[lb_out.rd_tag]) else
                    report_value(lb_out.rd_tag, "address", exp_value[lb_out.rd_tag],
                                 lb_out.address);
                assert (lb_out.mem_size == exp_size[lb_out.rd_tag]) else
                    report_value(lb_out.rd_tag, "mem_size", word_t'(exp_size[lb_out.rd_tag]),
                                 word_t'(lb_out.mem_size));
            end
        end
        if (!reset && branch_out.valid) begin
            take_result(branch_out.rob_tag, kind_br, "branch_out", ok);
            if (ok) begin
                assert (branch_out.target == exp_value[branch_out.rob_tag]) else
                    report_value(branch_out.rob_tag, "target", exp_value[branch_out.rob_tag],
                                 branch_out.target);
                assert (branch_out.taken == exp_taken[branch_out.rob_tag]) else
                    report_value(branch_out.rob_tag, "taken",
                                 word_t'(exp_taken[branch_out.rob_tag]),
                                 word_t'(branch_out.taken));
            end
        end
    end

    initial begin
        ready_entry_t e;
        void'($urandom(32'hdddc_163c));
        reset = 1'b1;
        issue_req = 1'b0;
        issue_entry = '0;
        next_tag = '0;
        pending_count = 0;
        error_count = 0;
        check_count = 0;
        for (int t = 0; t < num_tags; t++) pending[t] = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        begin_test("reset");
        repeat (4) begin
            @(negedge clock);
            assert (!issue_ack && !cdb.valid && !lb_out.valid && !branch_out.valid) else
                note_failure("Handshake or result valid went high before any request");
            check_count++;
            test_checks++;
        end
        end_test();

        begin_test("alu");
        for (int f = 0; f < 10; f++) begin
            issue(make_entry(fu_alu, alu_func_t'(f), opa_rs1, opb_rs2, 3'd0), kind_cdb);
            issue(make_entry(fu_alu, alu_func_t'(f), opa_rs1, opb_i_imm, 3'd0), kind_cdb);
        end
        end_test();

        begin_test("branch");
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 2 || f3 == 3) continue;  // No branch with these codes
            e = make_entry(fu_alu, alu_add, opa_pc, opb_b_imm, 3'(f3));
            e.instr.cond_branch = 1'b1;
            if (f3 == 0) e.rs2_value = e.rs1_value;  // Taken BEQ
            issue(e, kind_br);
        end
        e = make_entry(fu_alu, alu_add, opa_pc, opb_j_imm, 3'd0);  // JAL
        e.instr.uncond_branch = 1'b1;
        issue(e, kind_br);
        e = make_entry(fu_alu, alu_add, opa_rs1, opb_i_imm, 3'd0);  // JALR
        e.instr.uncond_branch = 1'b1;
        issue(e, kind_br);
        end_test();

        begin_test("load_store");
        for (int k = 0; k < 3; k++) begin
            e = make_entry(fu_mem, alu_add, opa_rs1, opb_i_imm, 3'(k));
            e.instr.rd_mem = 1'b1;
            issue(e, kind_lb);
            issue(make_entry(fu_mem, alu_add, opa_rs1, opb_s_imm, 3'(k)), kind_cdb);
        end
        end_test();

        begin_test("multiply");
        repeat (4) issue(make_entry(fu_mult, alu_add, opa_rs1, opb_rs2, 3'd0), kind_cdb);
        end_test();

        // ALU entry right behind a multiply meets the product on the CDB
        begin_test("collision");
        repeat (4) begin
            issue(make_entry(fu_mult, alu_add, opa_rs1, opb_rs2, 3'd0), kind_cdb);
            e = make_entry(fu_alu, alu_func_t'($urandom_range(9)), opa_rs1, opb_rs2, 3'd0);
            issue(e, kind_cdb);
        end
        end_test();

        $display("Summary: %0d results checked, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issue_req,
    input  exec_pkg::ready_entry_t   issue_entry,
    output logic                     issue_ack,
    output exec_pkg::cdb_t           cdb,
    output exec_pkg::lb_packet_t     lb_out,
    output exec_pkg::branch_result_t branch_out
);
    import exec_pkg::*;

    ready_entry_t   entry_q;
    logic           mult_start;
    cdb_t           alu_cdb;
    branch_result_t alu_branch;
    cdb_t           mem_cdb;
    lb_packet_t     mem_lb;
    cdb_t           mult_cdb;

    issue_ctrl u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .issue_req  (issue_req),
        .issue_entry(issue_entry),
        .alu_cdb    (alu_cdb),
        .alu_branch (alu_branch),
        .mem_cdb    (mem_cdb),
        .mem_lb     (mem_lb),
        .mult_cdb   (mult_cdb),
        .issue_ack  (issue_ack),
        .entry_q    (entry_q),
        .mult_start (mult_start),
        .cdb        (cdb),
        .lb_out     (lb_out),
        .branch_out (branch_out)
    );

    alu_unit u_alu_unit (.entry(entry_q), .cdb_res(alu_cdb), .branch_res(alu_branch));

    address_unit u_addr_unit (.entry(entry_q), .store_res(mem_cdb), .lb_res(mem_lb));

    // MUL takes its operands straight from the source values
    mult_pipe u_mult (
        .clock   (clock),
        .reset   (reset),
        .start   (mult_start),
        .mcand   (entry_q.rs1_value),
        .mplier  (entry_q.rs2_value),
        .tag_in  (entry_q.rd_tag),
        .mult_cdb(mult_cdb)
    );

endmodule

// File: logic/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issue_req,
    input  exec_pkg::ready_entry_t   issue_entry,
    input  exec_pkg::cdb_t           alu_cdb,
    input  exec_pkg::branch_result_t alu_branch,
    input  exec_pkg::cdb_t           mem_cdb,
    input  exec_pkg::lb_packet_t     mem_lb,
    input  exec_pkg::cdb_t           mult_cdb,
    output logic                     issue_ack,
    output exec_pkg::ready_entry_t   entry_q,
    output logic                     mult_start,
    output exec_pkg::cdb_t           cdb,
    output exec_pkg::lb_packet_t     lb_out,
    output exec_pkg::branch_result_t branch_out
);
    import exec_pkg::*;

    ctrl_state_t state;
    logic        capture;

    assign capture = (state == st_idle) && issue_req && !issue_ack;

    // Entry stays put until the next capture
    always_ff @(posedge clock) begin
        if (capture) begin
            entry_q <= issue_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            issue_ack  <= 1'b0;
            mult_start <= 1'b0;
            cdb        <= '0;
            lb_out     <= '0;
            branch_out <= '0;
        end else begin
            mult_start       <= 1'b0;
            cdb              <= mult_cdb;  // Multiplier owns the bus when valid
            lb_out.valid     <= 1'b0;
            branch_out.valid <= 1'b0;

            case (state)
                st_idle: begin
                    if (capture) begin
                        state <= st_busy;
                    end
                end
                st_busy, st_hold: begin
                    if (entry_q.instr.fu_kind == fu_mult) begin
                        mult_start <= 1'b1;
                        issue_ack  <= 1'b1;
                        state      <= st_ack_wait;
                    end else if (mult_cdb.valid) begin
                        state <= st_hold;  // Retry once the multiplier frees the CDB
                    end else begin
                        if (entry_q.instr.fu_kind == fu_mem) begin
                            cdb    <= mem_cdb;
                            lb_out <= mem_lb;
                        end else begin
                            cdb        <= alu_cdb;
                            branch_out <= alu_branch;
                        end
                        issue_ack <= 1'b1;
                        state     <= st_ack_wait;
                    end
                end
                st_ack_wait: begin
                    if (!issue_req) begin
                        issue_ack <= 1'b0;
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: logic/mult_pipe.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module mult_pipe #(
    parameter int num_stages = `MULT_STAGES
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               start,
    input  exec_pkg::word_t    mcand,
    input  exec_pkg::word_t    mplier,
    input  exec_pkg::rob_tag_t tag_in,
    output exec_pkg::cdb_t     mult_cdb
);
    import exec_pkg::*;

    localparam int chunk_bits = `XLEN / num_stages;

    word_t           product_chain [num_stages+1];
    word_t           mplier_chain  [num_stages+1];
    word_t           mcand_chain   [num_stages+1];
    logic [num_stages:0] done_chain;
    rob_tag_t        tag_q         [num_stages];

    assign product_chain[0] = '0;
    assign mplier_chain[0]  = mplier;
    assign mcand_chain[0]   = mcand;
    assign done_chain[0]    = start;

    for (genvar i = 0; i < num_stages; i++) begin : g_stage
        mult_stage #(.chunk_bits(chunk_bits)) u_stage (
            .clock      (clock),
            .reset      (reset),
            .start      (done_chain[i]),
            .product_in (product_chain[i]),
            .mplier_in  (mplier_chain[i]),
            .mcand_in   (mcand_chain[i]),
            .done       (done_chain[i+1]),
            .product_out(product_chain[i+1]),
            .mplier_out (mplier_chain[i+1]),
            .mcand_out  (mcand_chain[i+1])
        );

        // Tag moves with its product
        always_ff @(posedge clock) begin
            tag_q[i] <= (i == 0) ? tag_in : tag_q[(i == 0) ? 0 : i-1];
        end
    end

    assign mult_cdb.valid   = done_chain[num_stages];
    assign mult_cdb.value   = product_chain[num_stages];
    assign mult_cdb.rob_tag = tag_q[num_stages-1];

endmodule

// File: logic/mult_stage.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module mult_stage #(
    parameter int chunk_bits = `XLEN / `MULT_STAGES
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            start,
    input  exec_pkg::word_t product_in,
    input  exec_pkg::word_t mplier_in,
    input  exec_pkg::word_t mcand_in,
    output logic            done,
    output exec_pkg::word_t product_out,
    output exec_pkg::word_t mplier_out,
    output exec_pkg::word_t mcand_out
);
    import exec_pkg::*;

    word_t prod_q;
    word_t partial_q;
    word_t partial;

    assign partial     = mcand_in * mplier_in[chunk_bits-1:0];  // Low bits only
    assign product_out = prod_q + partial_q;

    always_ff @(posedge clock) begin
        prod_q     <= product_in;
        partial_q  <= partial;
        mplier_out <= mplier_in >> chunk_bits;  // Next chunk moves down
        mcand_out  <= mcand_in << chunk_bits;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

endmodule

// File: logic/address_unit.sv
`timescale 1ns/1ps

module address_unit (
    input  exec_pkg::ready_entry_t entry,
    output exec_pkg::cdb_t         store_res,
    output exec_pkg::lb_packet_t   lb_res
);
    import exec_pkg::*;

    word_t     base;
    word_t     offset;
    alu_func_t func;
    word_t     address;

    operand_select u_opsel (.entry(entry), .opa(base), .opb(offset), .func(func));

    alu u_adder (.opa(base), .opb(offset), .func(func), .result(address));

    // Load goes to the load buffer
    assign lb_res.valid    = entry.instr.rd_mem;
    assign lb_res.address  = address;
    assign lb_res.rd_tag   = entry.rd_tag;
    assign lb_res.mem_size = entry.instr.inst[14:12];

    // Store broadcasts its address
    assign store_res.valid   = ~entry.instr.rd_mem;
    assign store_res.value   = address;
    assign store_res.rob_tag = entry.rd_tag;

endmodule

// File: logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  exec_pkg::ready_entry_t   entry,
    output exec_pkg::cdb_t           cdb_res,
    output exec_pkg::branch_result_t branch_res
);
    import exec_pkg::*;

    word_t     opa;
    word_t     opb;
    alu_func_t func;
    word_t     result;
    logic      cond;
    logic      is_branch;

    operand_select u_opsel (.entry(entry), .opa(opa), .opb(opb), .func(func));

    alu u_alu (.opa(opa), .opb(opb), .func(func), .result(result));

    // Branch condition on the raw source values
    always_comb begin
        case (entry.instr.inst[14:12])
            3'b000:  cond = entry.rs1_value == entry.rs2_value;                  // BEQ
            3'b001:  cond = entry.rs1_value != entry.rs2_value;                  // BNE
            3'b100:  cond = $signed(entry.rs1_value) < $signed(entry.rs2_value);  // BLT
            3'b101:  cond = $signed(entry.rs1_value) >= $signed(entry.rs2_value); // BGE
            3'b110:  cond = entry.rs1_value < entry.rs2_value;                   // BLTU
            3'b111:  cond = entry.rs1_value >= entry.rs2_value;                  // BGEU
            default: cond = 1'b0;
        endcase
    end

    assign is_branch = entry.instr.cond_branch | entry.instr.uncond_branch;

    assign cdb_res.valid   = ~is_branch;
    assign cdb_res.value   = result;
    assign cdb_res.rob_tag = entry.rd_tag;

    assign branch_res.valid   = is_branch;
    assign branch_res.taken   = entry.instr.uncond_branch | (entry.instr.cond_branch & cond);
    assign branch_res.target  = result;  // Operand sum from the ALU
    assign branch_res.rob_tag = entry.rd_tag;

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  exec_pkg::word_t     opa,
    input  exec_pkg::word_t     opb,
    input  exec_pkg::alu_func_t func,
    output exec_pkg::word_t     result
);
    import exec_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = opb[4:0];
    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_and:  result = opa & opb;
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            alu_slt:  result = word_t'(lt_signed);
            alu_sltu: result = word_t'(lt_unsigned);
            alu_sll:  result = opa << shamt;
            alu_srl:  result = opa >> shamt;
            alu_sra:  result = word_t'($signed(opa) >>> shamt);  // Keeps the sign bit
            default:  result = 32'hfacebeec;
        endcase
    end

endmodule

// File: logic/operand_select.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module operand_select (
    input  exec_pkg::ready_entry_t entry,
    output exec_pkg::word_t        opa,
    output exec_pkg::word_t        opb,
    output exec_pkg::alu_func_t    func
);
    import exec_pkg::*;

    decoded_instr_t instr;

    assign instr = entry.instr;
    assign func  = instr.alu_func;

    always_comb begin
        case (instr.opa_select)
            opa_rs1:  opa = entry.rs1_value;
            opa_npc:  opa = instr.npc;
            opa_pc:   opa = instr.pc;
            opa_zero: opa = '0;
            default:  opa = 32'hdeadfbac;  // Bad select marker
        endcase
    end

    // Codes 6 and 7 are unused
    always_comb begin
        case (instr.opb_select)
            opb_rs2:   opb = entry.rs2_value;
            opb_i_imm: opb = `RV32_IMM_I(instr.inst);
            opb_s_imm: opb = `RV32_IMM_S(instr.inst);
            opb_b_imm: opb = `RV32_IMM_B(instr.inst);
            opb_u_imm: opb = `RV32_IMM_U(instr.inst);
            opb_j_imm: opb = `RV32_IMM_J(instr.inst);
            default:   opb = 32'hfacefeed;  // Shows up on a bad select
        endcase
    end

endmodule

// File: logic/exec_pkg.sv
`include "exec_defs.svh"

package exec_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_func_t;

    typedef enum logic [1:0] {opa_rs1, opa_npc, opa_pc, opa_zero} opa_sel_t;

    typedef enum logic [2:0] {
        opb_rs2, opb_i_imm, opb_s_imm, opb_b_imm, opb_u_imm, opb_j_imm
    } opb_sel_t;

    typedef enum logic [1:0] {fu_alu, fu_mem, fu_mult} fu_kind_t;

    // Issue handshake FSM
    typedef enum logic [1:0] {st_idle, st_busy, st_hold, st_ack_wait} ctrl_state_t;

    typedef struct packed {
        logic [31:0] inst;
        word_t       pc;
        word_t       npc;
        opa_sel_t    opa_select;
        opb_sel_t    opb_select;
        alu_func_t   alu_func;
        fu_kind_t    fu_kind;
        logic        cond_branch;
        logic        uncond_branch;
        logic        rd_mem;       // Load when set, store otherwise
    } decoded_instr_t;

    typedef struct packed {
        decoded_instr_t instr;
        word_t          rs1_value;
        word_t          rs2_value;
        rob_tag_t       rd_tag;
    } ready_entry_t;

    typedef struct packed {
        logic     valid;
        word_t    value;
        rob_tag_t rob_tag;
    } cdb_t;

    typedef struct packed {
        logic       valid;
        word_t      address;
        rob_tag_t   rd_tag;
        logic [2:0] mem_size;   // funct3 of the load
    } lb_packet_t;

    typedef struct packed {
        logic     valid;
        logic     taken;
        word_t    target;
        rob_tag_t rob_tag;
    } branch_result_t;

endpackage

// File: logic/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define XLEN 32
`define MULT_STAGES 4   // Must divide XLEN evenly
`define ROB_TAG_BITS 5

// Sign-extended immediates of an RV32 instruction word
`define RV32_IMM_I(inst) {{21{inst[31]}}, inst[30:20]}
`define RV32_IMM_S(inst) {{21{inst[31]}}, inst[30:25], inst[11:7]}
`define RV32_IMM_B(inst) {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}
`define RV32_IMM_U(inst) {inst[31:12], 12'b0}
`define RV32_IMM_J(inst) {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}

`endif
